/* files.f */
+incdir+include
rtl/capture_pkg.sv
rtl/mem_cmd_if.sv
rtl/sample_fifo.sv
rtl/capture_writer.sv
rtl/playback_reader.sv
rtl/mem_arbiter.sv
rtl/sample_ram.sv
rtl/capture_top.sv
tests/tb_capture_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the capture testbench with Verilator, run it, and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_capture_top \
   -Mdir obj_dir -o sim_capture > build.log 2>&1 \
   && ./obj_dir/sim_capture > sim.log 2>&1 \
   || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Done: errors found" sim.log \
   && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running totals for the summary line
int err_cnt  = 0;
int test_cnt = 0;

task automatic check_sample(input string name, input capture_pkg::sample_t got,
                            input capture_pkg::sample_t exp);
   test_cnt++;
   if (got === exp)
      $display("PASS %s: got %h", name, got);
   else
   begin
      err_cnt++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
   end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
   test_cnt++;
   if (got === exp)
      $display("PASS %s: got %b", name, got);
   else
   begin
      err_cnt++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
   end
endtask

task automatic check_count(input string name, input int got, input int exp);
   test_cnt++;
   if (got == exp)
      $display("PASS %s: got %0d", name, got);
   else
   begin
      err_cnt++;
      $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
   end
endtask

`endif

/* tests/tb_capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_capture_top;
   import capture_pkg::*;

   `include "tb_checks.svh"

   localparam int N_PHASES      = 5;
   localparam int PUSH_TIMEOUT  = 2000;
   localparam int DONE_TIMEOUT  = 2000;
   localparam int SETTLE_CYCLES = 24;

   typedef struct packed
   {
      int   n_samples;
      int   valid_duty;
      int   tx_duty;
      int   exp_pops;
      logic do_start;
      logic quiet_tx;
      logic exp_tx_valid;
      logic exp_capture_done;
      logic exp_replay_done;
   } phase_entry_t;

   logic         bb_clk;
   logic         rst;
   logic         start;
   logic         sample_valid;
   sample_t      sample_data;
   logic         sample_ready;
   logic         tx_valid;
   sample_t      tx_data;
   logic         tx_ready;
   logic         capture_done;
   logic         replay_done;

   phase_entry_t phase_tab [N_PHASES];
   integer       seed        = 32'h7a56;
   int           valid_roll  = 0;
   int           ready_roll  = 0;
   int           valid_duty  = 0;
   int           tx_duty     = 0;
   int           push_target = 0;
   int           push_idx    = 0;
   int           pop_idx     = 0;
   int           quiet_hits  = 0;
   logic         quiet_tx    = 1'b0;

   capture_top dut (
      .bb_clk       (bb_clk),
      .rst          (rst),
      .start        (start),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .sample_ready (sample_ready),
      .tx_valid     (tx_valid),
      .tx_data      (tx_data),
      .tx_ready     (tx_ready),
      .capture_done (capture_done),
      .replay_done  (replay_done)
   );

   // Word i of the burst
   function automatic sample_t sample_value(input int idx);
      return sample_t'(idx * 3 + 1);
   endfunction

   initial
   begin
      bb_clk = 1'b0;
      forever #10 bb_clk = ~bb_clk;
   end

   // ************************************************************
   // Per-cycle input drive and output monitor
   // ************************************************************
   initial
   begin
      sample_valid = 1'b0;
      sample_data  = '0;
      tx_ready     = 1'b0;
      forever
      begin
         @(posedge bb_clk);
         #2;
         valid_roll   = $unsigned($random(seed)) % 100;
         ready_roll   = $unsigned($random(seed)) % 100;
         sample_valid = (push_idx < push_target) && (valid_roll < valid_duty);
         sample_data  = sample_value(push_idx);
         tx_ready     = (ready_roll < tx_duty);
      end
   end

   // Handshakes seen here complete on the next rising edge
   always @(negedge bb_clk)
   begin
      if (!rst)
      begin
         if (sample_valid && sample_ready)
            push_idx++;
         if (tx_valid && tx_ready)
         begin
            check_sample($sformatf("tx_data word %0d", pop_idx), tx_data, sample_value(pop_idx));
            pop_idx++;
         end
         if (quiet_tx && tx_valid)
            quiet_hits++;
      end
   end

   task automatic report_timeout(input string what);
      err_cnt++;
      $display("Timeout: %s", what);
   endtask

   task automatic wait_pushes(input int limit);
      int cyc = 0;
      while (push_idx < push_target && cyc < limit)
      begin
         @(posedge bb_clk);
         #1;
         cyc++;
      end
      if (push_idx < push_target)
         report_timeout($sformatf("only %0d of %0d samples were accepted",
                                  push_idx, push_target));
   endtask

   task automatic wait_capture_done(input int limit);
      int cyc = 0;
      while (!capture_done && cyc < limit)
      begin
         @(posedge bb_clk);
         #1;
         cyc++;
      end
      if (!capture_done)
         report_timeout("capture_done never rose after the last sample");
   endtask

   task automatic wait_replay_done(input int limit);
      int cyc = 0;
      while (!replay_done && cyc < limit)
      begin
         @(posedge bb_clk);
         #1;
         cyc++;
      end
      if (!replay_done)
         report_timeout($sformatf("replay_done never rose, %0d words popped", pop_idx));
   endtask

   task automatic run_phase(input int p);
      phase_entry_t e;
      int           hits_before;
      e = phase_tab[p];
      if (e.do_start)
      begin
         @(posedge bb_clk);
         #2;
         start = 1'b1;
         @(posedge bb_clk);
         #2;
         start = 1'b0;
      end
      @(posedge bb_clk);
      #1;
      hits_before = quiet_hits;
      quiet_tx    = e.quiet_tx;
      valid_duty  = e.valid_duty;
      tx_duty     = e.tx_duty;
      push_target = push_target + e.n_samples;
      wait_pushes(PUSH_TIMEOUT);
      if (e.exp_capture_done)
         wait_capture_done(DONE_TIMEOUT);
      if (e.exp_replay_done)
         wait_replay_done(DONE_TIMEOUT);
      repeat (SETTLE_CYCLES) @(posedge bb_clk);
      #1;
      check_flag($sformatf("phase %0d capture_done", p), capture_done, e.exp_capture_done);
      check_flag($sformatf("phase %0d replay_done", p), replay_done, e.exp_replay_done);
      check_flag($sformatf("phase %0d tx_valid", p), tx_valid, e.exp_tx_valid);
      // Pops only happen while tx_ready is driven
      if (e.tx_duty > 0)
         check_count($sformatf("phase %0d words popped", p), pop_idx, e.exp_pops);
      if (e.quiet_tx)
         check_count($sformatf("phase %0d early tx_valid cycles", p),
                     quiet_hits - hits_before, 0);
      quiet_tx = 1'b0;
      $display("Phase %0d finished, %0d samples in, %0d words out", p, push_idx, pop_idx);
   endtask

   // ************************************************************
   // Main sequence
   // ************************************************************
   initial
   begin
      rst   = 1'b1;
      start = 1'b0;
      // samples, valid %, tx_ready %, pops, start, quiet, tx_valid, capture_done, replay_done
      phase_tab[0] = '{8,  60,  0,   0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      phase_tab[1] = '{16, 70,  0,   0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
      phase_tab[2] = '{40, 100, 0,   0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
      phase_tab[3] = '{0,  0,   40,  CAPTURE_DEPTH, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
      phase_tab[4] = '{0,  0,   100, CAPTURE_DEPTH, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1};
      repeat (8) @(posedge bb_clk);
      #2;
      rst = 1'b0;
      @(posedge bb_clk);
      #1;
      check_flag("tx_valid after reset", tx_valid, 1'b0);
      check_flag("capture_done after reset", capture_done, 1'b0);
      check_flag("replay_done after reset", replay_done, 1'b0);
      check_flag("sample_ready after reset", sample_ready, 1'b1);
      for (int p = 0; p < N_PHASES; p++)
         run_phase(p);
      $display("Checks: %0d, errors: %0d", test_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/capture_top.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_top (
   input  logic                 bb_clk,
   input  logic                 rst,
   input  logic                 start,
   input  logic                 sample_valid,
   input  capture_pkg::sample_t sample_data,
   output logic                 sample_ready,
   output logic                 tx_valid,
   output capture_pkg::sample_t tx_data,
   input  logic                 tx_ready,
   output logic                 capture_done,
   output logic                 replay_done
);
   import capture_pkg::*;

   logic [ACQ_CNT_W-1:0] acq_count;
   sample_t              acq_data;
   logic                 acq_pop;
   logic                 acq_full;
   logic                 tx_push;
   sample_t              tx_push_data;
   logic                 tx_pop;
   logic                 tx_empty;
   logic [ADDR_W:0]      words_written;
   capture_phase_t       phase;

   mem_cmd_if wr_port ();
   mem_cmd_if rd_port ();
   mem_cmd_if ram_port ();

   assign sample_ready = !acq_full;
   assign tx_valid     = !tx_empty;
   assign tx_pop       = tx_ready && !tx_empty;
   assign capture_done = (phase == PHASE_DONE);

   // ************************************************************
   // Acquisition and transmit buffering
   // ************************************************************
   sample_fifo #(.DEPTH(ACQ_DEPTH)) acq_fifo (
      .bb_clk    (bb_clk),
      .rst       (rst),
      .push      (sample_valid),
      .push_data (sample_data),
      .pop       (acq_pop),
      .pop_data  (acq_data),
      .full      (acq_full),
      .empty     (),
      .count     (acq_count)
   );

   sample_fifo #(.DEPTH(TX_DEPTH)) tx_fifo (
      .bb_clk    (bb_clk),
      .rst       (rst),
      .push      (tx_push),
      .push_data (tx_push_data),
      .pop       (tx_pop),
      .pop_data  (tx_data),
      .full      (),
      .empty     (tx_empty),
      .count     ()
   );

   // ************************************************************
   // Movers, arbitration and memory
   // ************************************************************
   capture_writer u_writer (
      .bb_clk        (bb_clk),
      .rst           (rst),
      .start         (start),
      .acq_count     (acq_count),
      .acq_data      (acq_data),
      .acq_pop       (acq_pop),
      .mem           (wr_port.requester),
      .words_written (words_written),
      .phase         (phase)
   );

   playback_reader u_reader (
      .bb_clk        (bb_clk),
      .rst           (rst),
      .words_written (words_written),
      .tx_pop        (tx_pop),
      .mem           (rd_port.requester),
      .tx_push       (tx_push),
      .tx_push_data  (tx_push_data),
      .replay_done   (replay_done)
   );

   mem_arbiter u_arbiter (
      .bb_clk (bb_clk),
      .rst    (rst),
      .wr_req (wr_port.memory),
      .rd_req (rd_port.memory),
      .ram    (ram_port.requester)
   );

   sample_ram u_ram (
      .bb_clk (bb_clk),
      .rst    (rst),
      .port   (ram_port.memory)
   );

endmodule

`default_nettype wire

/* rtl/sample_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_ram (
   input  logic      bb_clk,
   input  logic      rst,
   mem_cmd_if.memory port
);
   import capture_pkg::*;

   sample_t                          mem [CAPTURE_DEPTH];
   logic [$clog2(REFRESH_PERIOD)-1:0] ref_cnt;
   logic [RD_LATENCY-1:0]            vld_pipe;
   sample_t                          data_pipe [RD_LATENCY];
   logic [$clog2(CAPTURE_DEPTH)-1:0] word_addr;
   logic                             accept;

   // Refresh steals the last slot of every period
   assign port.cmd_ready = (ref_cnt != REFRESH_PERIOD-1);

   assign accept    = port.cmd_valid && port.cmd_ready;
   assign word_addr = port.cmd_addr[$clog2(CAPTURE_DEPTH)-1:0];

   assign port.rd_valid = vld_pipe[RD_LATENCY-1];
   assign port.rd_data  = data_pipe[RD_LATENCY-1];

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         ref_cnt  <= '0;
         vld_pipe <= '0;
      end
      else
      begin
         ref_cnt  <= ref_cnt + 1'b1;
         vld_pipe <= {vld_pipe[RD_LATENCY-2:0], accept && !port.cmd_write};
      end
   end

   // Array and read data pipeline
   always_ff @(posedge bb_clk)
   begin
      if (accept && port.cmd_write)
         mem[word_addr] <= port.cmd_wdata;
      data_pipe[0] <= mem[word_addr];
      for (int i = 1; i < RD_LATENCY; i++)
         data_pipe[i] <= data_pipe[i-1];
   end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
   input  logic        bb_clk,
   input  logic        rst,
   mem_cmd_if.memory    wr_req,
   mem_cmd_if.memory    rd_req,
   mem_cmd_if.requester ram
);
   import capture_pkg::*;

   // High means the reader wins a tie
   logic rd_first;
   logic grant_wr;
   logic grant_rd;
   logic cmd_accept;

   assign grant_rd = rd_req.cmd_valid && (!wr_req.cmd_valid || rd_first);
   assign grant_wr = wr_req.cmd_valid && !grant_rd;

   // ************************************************************
   // Command mux
   // ************************************************************
   assign ram.cmd_valid = wr_req.cmd_valid || rd_req.cmd_valid;
   assign ram.cmd_write = grant_rd ? rd_req.cmd_write : wr_req.cmd_write;
   assign ram.cmd_addr  = grant_rd ? rd_req.cmd_addr  : wr_req.cmd_addr;
   assign ram.cmd_wdata = grant_rd ? rd_req.cmd_wdata : wr_req.cmd_wdata;

   assign wr_req.cmd_ready = grant_wr && ram.cmd_ready;
   assign rd_req.cmd_ready = grant_rd && ram.cmd_ready;

   assign cmd_accept = ram.cmd_valid && ram.cmd_ready;

   // Only the reader issues reads
   assign rd_req.rd_valid = ram.rd_valid;
   assign rd_req.rd_data  = ram.rd_data;
   assign wr_req.rd_valid = 1'b0;
   assign wr_req.rd_data  = '0;

   // Whoever was just served drops to the back
   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
         rd_first <= 1'b0;
      else if (cmd_accept)
         rd_first <= grant_wr;
   end

endmodule

`default_nettype wire

/* rtl/playback_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module playback_reader (
   input  logic                          bb_clk,
   input  logic                          rst,
   input  logic [capture_pkg::ADDR_W:0]  words_written,
   input  logic                          tx_pop,
   mem_cmd_if.requester                  mem,
   output logic                          tx_push,
   output capture_pkg::sample_t          tx_push_data,
   output logic                          replay_done
);
   import capture_pkg::*;

   logic [ADDR_W:0]    rd_ptr;
   logic [ADDR_W:0]    pop_cnt;
   logic [TX_CNT_W-1:0] credits;
   logic               armed;
   logic               rd_accept;

   // words_written only grows, so this never drops once set
   assign armed = (words_written >= PREFILL_WORDS);

   // ************************************************************
   // Read requests
   // ************************************************************
   // Request stays up until accepted since none of its terms can fall
   assign mem.cmd_valid = armed && (rd_ptr < words_written) && (credits != '0);
   assign mem.cmd_write = 1'b0;
   assign mem.cmd_addr  = rd_ptr[ADDR_W-1:0];
   assign mem.cmd_wdata = '0;

   assign rd_accept = mem.cmd_valid && mem.cmd_ready;

   // Credits guarantee room, so returns go straight into the tx FIFO
   assign tx_push      = mem.rd_valid;
   assign tx_push_data = mem.rd_data;

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         rd_ptr  <= '0;
         credits <= TX_CNT_W'(TX_DEPTH);
      end
      else
      begin
         if (rd_accept)
            rd_ptr <= rd_ptr + 1'b1;

         case ({rd_accept, tx_pop})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // ************************************************************
   // Completion
   // ************************************************************
   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         pop_cnt     <= '0;
         replay_done <= 1'b0;
      end
      else if (tx_pop)
      begin
         pop_cnt <= pop_cnt + 1'b1;
         if (pop_cnt == CAPTURE_DEPTH-1)
            replay_done <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* rtl/capture_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module capture_writer (
   input  logic                              bb_clk,
   input  logic                              rst,
   input  logic                              start,
   input  logic [capture_pkg::ACQ_CNT_W-1:0] acq_count,
   input  capture_pkg::sample_t              acq_data,
   output logic                              acq_pop,
   mem_cmd_if.requester                      mem,
   output logic [capture_pkg::ADDR_W:0]      words_written,
   output capture_pkg::capture_phase_t       phase
);
   import capture_pkg::*;

   logic                          block_active;
   logic [$clog2(BLOCK_LEN)-1:0]  blk_cnt;
   logic                          wr_accept;

   // Write pointer is the low part of the word count
   assign mem.cmd_valid = block_active;
   assign mem.cmd_write = 1'b1;
   assign mem.cmd_addr  = words_written[ADDR_W-1:0];
   assign mem.cmd_wdata = acq_data;

   assign wr_accept = mem.cmd_valid && mem.cmd_ready;

   // FIFO head leaves on the same edge as its write
   assign acq_pop   = wr_accept;

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         phase         <= PHASE_IDLE;
         block_active  <= 1'b0;
         blk_cnt       <= '0;
         words_written <= '0;
      end
      else
      begin
         case (phase)
            PHASE_IDLE:
               if (start)
                  phase <= PHASE_CAPTURING;
            PHASE_CAPTURING:
               if (!block_active)
               begin
                  // Wait for a full block in the acquisition FIFO
                  if (acq_count >= BLOCK_LEN)
                  begin
                     block_active <= 1'b1;
                     blk_cnt      <= '0;
                  end
               end
               else if (wr_accept)
               begin
                  words_written <= words_written + 1'b1;
                  blk_cnt       <= blk_cnt + 1'b1;
                  if (blk_cnt == BLOCK_LEN-1)
                     block_active <= 1'b0;
                  if (words_written == CAPTURE_DEPTH-1)
                     phase <= PHASE_DONE;
               end
            default:
               phase <= phase;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/sample_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                         bb_clk,
   input  logic                         rst,
   input  logic                         push,
   input  capture_pkg::sample_t         push_data,
   input  logic                         pop,
   output capture_pkg::sample_t         pop_data,
   output logic                         full,
   output logic                         empty,
   output logic [$clog2(DEPTH+1)-1:0]   count
);
   import capture_pkg::*;

   sample_t                    mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic                       do_push;
   logic                       do_pop;

   assign full     = (count == DEPTH);
   assign empty    = (count == '0);
   assign do_push  = push && !full;
   assign do_pop   = pop && !empty;

   // Head word is visible without a read cycle
   assign pop_data = mem[rd_ptr];

   always_ff @(posedge bb_clk)
   begin
      if (do_push)
         mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge bb_clk or posedge rst)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;

         // Push and pop together leave the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/mem_cmd_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface mem_cmd_if;
   import capture_pkg::*;

   logic    cmd_valid;
   logic    cmd_write;
   addr_t   cmd_addr;
   sample_t cmd_wdata;
   logic    cmd_ready;

   // Read return, one pulse per accepted read
   logic    rd_valid;
   sample_t rd_data;

   modport requester (output cmd_valid, cmd_write, cmd_addr, cmd_wdata,
                      input  cmd_ready, rd_valid, rd_data);

   modport memory (input  cmd_valid, cmd_write, cmd_addr, cmd_wdata,
                   output cmd_ready, rd_valid, rd_data);

endinterface

`default_nettype wire

/* rtl/capture_pkg.sv */
`default_nettype none

package capture_pkg;

   // ************************************************************
   // Sizes
   // ************************************************************
   localparam int DATA_W         = 16;
   localparam int ADDR_W         = 7;
   localparam int CAPTURE_DEPTH  = 64;
   localparam int BLOCK_LEN      = 8;

   // Playback may start once this many words sit in memory
   localparam int PREFILL_WORDS  = 32;

   localparam int ACQ_DEPTH      = 16;
   localparam int TX_DEPTH       = 8;
   localparam int ACQ_CNT_W      = $clog2(ACQ_DEPTH + 1);
   localparam int TX_CNT_W       = $clog2(TX_DEPTH + 1);

   // RAM behaviour
   localparam int RD_LATENCY     = 2;
   localparam int REFRESH_PERIOD = 32;

   // ************************************************************
   // Types
   // ************************************************************
   typedef logic [DATA_W-1:0] sample_t;
   typedef logic [ADDR_W-1:0] addr_t;

   typedef enum logic [1:0]
   {
      PHASE_IDLE      = 2'd0,
      PHASE_CAPTURING = 2'd1,
      PHASE_DONE      = 2'd2
   } capture_phase_t;

endpackage

`default_nettype wire
